//--- include/cga_defs_defs.svh
// CGA sheet 33 definitions
`ifndef CGA_DEFS_DEFS_SVH
`define CGA_DEFS_DEFS_SVH

// Data path widths
`define CGA_WORD_W   16
`define CGA_CSBITS_W 64
`define CGA_LEVEL_W  4

// Bus source field, CSBITS 41..37
`define CGA_IDBS_LSB 37
`define CGA_IDBS_W   5

// Command field, CSBITS 36..32
`define CGA_COMM_LSB 32
`define CGA_COMM_W   5

// Literal field, CSBITS 15..0
`define CGA_LIT_W    16

// Microcode command codes seen on this sheet
`define CMD_NONE     5'h00
`define CMD_LOAD_PIE 5'h0A
`define CMD_LOAD_PL  5'h0B

`endif

//--- hw/cga_pkg.sv
// CGA sheet 33 types
`default_nettype none

`include "cga_defs_defs.svh"

package cga_pkg;

  // Internal data bus word
  typedef logic [`CGA_WORD_W-1:0] word_t;

  // Raw 64-bit microword as seen on CSBITS
  typedef logic [`CGA_CSBITS_W-1:0] csbits_t;

  // Program / interrupt level number
  typedef logic [`CGA_LEVEL_W-1:0] level_t;

  // One bit per interrupt level
  typedef logic [`CGA_WORD_W-1:0] int_vec_t;

  // Sources for the internal data bus (CSIDBS)
  typedef enum logic [`CGA_IDBS_W-1:0] {
    SRC_NONE   = 5'd0,
    SRC_CD     = 5'd1,
    SRC_LIT    = 5'd2,
    SRC_PIE    = 5'd3,
    SRC_STATUS = 5'd4
  } idb_src_e;

  // Decoded microword fields used on this sheet
  typedef struct packed {
    logic [8:0]             alui;  // CSALUI, bits 63..55
    idb_src_e               idbs;  // CSIDBS, bits 41..37
    logic [`CGA_COMM_W-1:0] comm;  // CSCOMM, bits 36..32
    word_t                  lit;   // CSBIT, bits 15..0
    logic [3:0]             rb;    // CSRB, bits 19..16
  } cs_fields_t;

  // Interrupt system state
  typedef struct packed {
    int_vec_t pending;  // Latched requests
    word_t    pie;      // Enable mask
    level_t   pl;       // Current program level
    level_t   pil;      // Highest enabled pending level
  } int_state_t;

endpackage

`default_nettype wire

//--- hw/microword_decode.sv
// Microword register and field decoder
`default_nettype none

`include "cga_defs_defs.svh"

module microword_decode
  import cga_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  logic       uclk,
  input  csbits_t    csbits,
  output cs_fields_t cs,
  output logic       cmd_strobe
);

  // Raw bus source code straight off the microword
  logic [`CGA_IDBS_W-1:0] idbs_raw;
  cs_fields_t             cs_d;

  assign idbs_raw = csbits[`CGA_IDBS_LSB +: `CGA_IDBS_W];

  // Field slicing
  always_comb begin
    cs_d.alui = csbits[`CGA_CSBITS_W-1 -: 9];
    cs_d.comm = csbits[`CGA_COMM_LSB +: `CGA_COMM_W];
    cs_d.lit  = csbits[`CGA_LIT_W-1:0];
    cs_d.rb   = csbits[`CGA_LIT_W +: 4];
    // Unknown source codes fall back to no source
    case (idbs_raw)
      SRC_CD:     cs_d.idbs = SRC_CD;
      SRC_LIT:    cs_d.idbs = SRC_LIT;
      SRC_PIE:    cs_d.idbs = SRC_PIE;
      SRC_STATUS: cs_d.idbs = SRC_STATUS;
      default:    cs_d.idbs = SRC_NONE;
    endcase
  end

  // Microword latch on the uclk strobe
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      cs         <= '0;
      cmd_strobe <= 1'b0;
    end else begin
      if (uclk) begin
        cs <= cs_d;
      end
      // Command valid for one cycle after each load
      cmd_strobe <= uclk;
    end
  end

endmodule

`default_nettype wire

//--- hw/int_latch.sv
// Interrupt request latch
`default_nettype none

module int_latch
  import cga_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  logic       alu_clk,
  input  logic [4:0] ibint_n,
  output int_vec_t   pending
);

  // Holding register, stands in for the 74374 on inverted ALUCLK
  // Bit 4 level 10, 3 level 11, 2 level 12, 1 level 13, 0 level 15
  // Only the five request lines of the octal latch are kept
  logic [4:0] q;
  logic [4:0] d;

  // Requests stored active high so a cleared latch means no request
  assign d = ~ibint_n;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (alu_clk) begin
      q <= d;
    end
  end

  // Spread latch bits onto their level positions
  always_comb begin
    pending     = '0;
    pending[10] = q[4];
    pending[11] = q[3];
    pending[12] = q[2];
    pending[13] = q[1];
    pending[15] = q[0];
  end

endmodule

`default_nettype wire

//--- hw/int_level.sv
// Interrupt enable mask and priority encoder
`default_nettype none

`include "cga_defs_defs.svh"

module int_level
  import cga_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  int_vec_t   pending,
  input  cs_fields_t cs,
  input  logic       cmd_strobe,
  input  word_t      idb,
  output int_state_t state,
  output logic       intrq_n
);

  word_t  pie;
  level_t pl;
  level_t pil_d;
  level_t pil_q;

  // Command decode, then held one cycle
  logic load_pie_d;
  logic load_pl_d;
  logic load_pie;
  logic load_pl;

  always_comb begin
    load_pie_d = 1'b0;
    load_pl_d  = 1'b0;
    if (cmd_strobe) begin
      case (cs.comm)
        `CMD_LOAD_PIE: load_pie_d = 1'b1;
        `CMD_LOAD_PL:  load_pl_d  = 1'b1;
        default:       ;
      endcase
    end
  end

  // Highest enabled pending level, zero when nothing is enabled
  always_comb begin : pil_enc
    int_vec_t req;
    req   = pending & pie;
    pil_d = '0;
    for (int i = 0; i < `CGA_WORD_W; i++) begin
      if (req[i]) begin
        pil_d = level_t'(i);
      end
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      load_pie <= 1'b0;
      load_pl  <= 1'b0;
      pie      <= '0;
      pl       <= '0;
      pil_q    <= '0;
      intrq_n  <= 1'b1;
    end else begin
      load_pie <= load_pie_d;
      load_pl  <= load_pl_d;
      // Registered bus catches up with the command's own source here
      if (load_pie) begin
        pie <= idb;
      end
      if (load_pl) begin
        pl <= idb[`CGA_LEVEL_W-1:0];
      end
      pil_q <= pil_d;
      // Request only above the running level
      intrq_n <= !(pil_d > pl);
    end
  end

  assign state = '{pending: pending, pie: pie, pl: pl, pil: pil_q};

endmodule

`default_nettype wire

//--- hw/idb_mux.sv
// Internal data bus driver
`default_nettype none

module idb_mux
  import cga_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  cs_fields_t cs,
  input  word_t      cd,
  input  int_state_t state,
  output word_t      idb
);

  word_t idb_d;
  word_t status;
  logic  int_req;

  // Local copy of the request, same compare as in int_level
  assign int_req = state.pil > state.pl;

  // Status word
  // pil in 15..12, pl in 11..8, request in bit 0
  assign status = {state.pil, state.pl, 7'b0000000, int_req};

  // Source select from CSIDBS
  always_comb begin
    case (cs.idbs)
      SRC_NONE:   idb_d = '0;
      SRC_CD:     idb_d = cd;
      SRC_LIT:    idb_d = cs.lit;
      SRC_PIE:    idb_d = state.pie;
      SRC_STATUS: idb_d = status;
      default:    idb_d = '0;
    endcase
  end

  // Bus output register
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      idb <= '0;
    end else begin
      idb <= idb_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/test_mux.sv
// Test port selector
`default_nettype none

module test_mux
  import cga_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  logic [2:0] sel_testmux,
  input  cs_fields_t cs,
  input  int_vec_t   pending,
  input  int_state_t state,
  input  logic       intrq_n,
  output logic [4:0] test_4_0
);

  logic [4:0] test_d;

  // Eight test groups
  always_comb begin
    case (sel_testmux)
      3'd0:    test_d = {pending[15], pending[13:10]};
      3'd1:    test_d = {intrq_n, state.pil};
      3'd2:    test_d = {1'b0, state.pl};
      3'd3:    test_d = cs.comm;
      3'd4:    test_d = cs.idbs;
      3'd5:    test_d = {1'b0, cs.rb};
      3'd6:    test_d = {state.pie[15], state.pie[13:10]};
      default: test_d = '0;
    endcase
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      test_4_0 <= '0;
    end else begin
      test_4_0 <= test_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/cga_33.sv
// ND120 CGA sheet 33 top
`default_nettype none

module cga_33
  import cga_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  // ALUCLK and UCLK as one-cycle strobes
  input  logic       alu_clk,
  input  logic       uclk,
  // Levels 10, 11, 12, 13, 15 from bit 4 down
  input  logic [4:0] ibint_n,
  input  csbits_t    csbits,
  input  word_t      cd,
  input  logic [2:0] sel_testmux,
  output word_t      fidb_out,
  output level_t     pil_3_0,
  output logic       intrq_n,
  output logic [4:0] test_4_0
);

  // Decoded microword
  cs_fields_t cs;
  logic       cmd_strobe;

  // Interrupt side
  int_vec_t   pending;
  int_state_t state;

  microword_decode u_microword_decode (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .uclk      (uclk),
    .csbits    (csbits),
    .cs        (cs),
    .cmd_strobe(cmd_strobe)
  );

  int_latch u_int_latch (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .alu_clk(alu_clk),
    .ibint_n(ibint_n),
    .pending(pending)
  );

  // Mask and level load from the bus output
  int_level u_int_level (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .pending   (pending),
    .cs        (cs),
    .cmd_strobe(cmd_strobe),
    .idb       (fidb_out),
    .state     (state),
    .intrq_n   (intrq_n)
  );

  idb_mux u_idb_mux (
    .sysclk(sysclk),
    .arst_n(arst_n),
    .cs    (cs),
    .cd    (cd),
    .state (state),
    .idb   (fidb_out)
  );

  test_mux u_test_mux (
    .sysclk     (sysclk),
    .arst_n     (arst_n),
    .sel_testmux(sel_testmux),
    .cs         (cs),
    .pending    (pending),
    .state      (state),
    .intrq_n    (intrq_n),
    .test_4_0   (test_4_0)
  );

  // PIL pins
  assign pil_3_0 = state.pil;

endmodule

`default_nettype wire

//--- tests/tb_cga_33.sv
// CGA sheet 33 testbench
`default_nettype none

module tb_cga_33
  import cga_pkg::*;
();

  localparam int          FIELDS        = 10;
  localparam int          MAX_STEPS     = 64;
  localparam int          SETTLE_CYCLES = 4;
  localparam int          MAX_CYCLES    = 2000;
  localparam logic [63:0] END_MARK      = 64'hff;

  // DUT ports
  logic       sysclk;
  logic       arst_n;
  logic       alu_clk;
  logic       uclk;
  logic [4:0] ibint_n;
  csbits_t    csbits;
  word_t      cd;
  logic [2:0] sel_testmux;
  word_t      fidb_out;
  level_t     pil_3_0;
  logic       intrq_n;
  logic [4:0] test_4_0;

  // Raw vector file, ten words per step
  logic [63:0] stim [0:FIELDS*MAX_STEPS-1];

  // Current step, unpacked
  logic [63:0] step_grp;
  logic [63:0] step_csbits;
  logic [63:0] step_cd;
  logic [63:0] step_ibint;
  logic [63:0] step_sel;
  logic [63:0] step_strb;
  logic [63:0] exp_fidb;
  logic [63:0] exp_pil;
  logic [63:0] exp_irq;
  logic [63:0] exp_test;

  int pass_cnt;
  int fail_cnt;
  int grp_fail;

  cga_33 uut (
    .sysclk     (sysclk),
    .arst_n     (arst_n),
    .alu_clk    (alu_clk),
    .uclk       (uclk),
    .ibint_n    (ibint_n),
    .csbits     (csbits),
    .cd         (cd),
    .sel_testmux(sel_testmux),
    .fidb_out   (fidb_out),
    .pil_3_0    (pil_3_0),
    .intrq_n    (intrq_n),
    .test_4_0   (test_4_0)
  );

  // 40 unit clock
  always #20 sysclk = ~sysclk;

  function automatic logic [63:0] stim_word(input int s, input int f);
    logic [9:0] addr;
    addr = 10'(s * FIELDS + f);
    return stim[addr];
  endfunction

  task automatic load_step(input int s);
    step_grp    = stim_word(s, 0);
    step_csbits = stim_word(s, 1);
    step_cd     = stim_word(s, 2);
    step_ibint  = stim_word(s, 3);
    step_sel    = stim_word(s, 4);
    step_strb   = stim_word(s, 5);
    exp_fidb    = stim_word(s, 6);
    exp_pil     = stim_word(s, 7);
    exp_irq     = stim_word(s, 8);
    exp_test    = stim_word(s, 9);
  endtask

  // Strobe bits, alu_clk on bit 1, uclk on bit 0
  task automatic apply_inputs();
    csbits      = step_csbits;
    cd          = step_cd[15:0];
    ibint_n     = step_ibint[4:0];
    sel_testmux = step_sel[2:0];
    alu_clk     = step_strb[1];
    uclk        = step_strb[0];
  endtask

  task automatic wait_cycles(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge sysclk);
    end
  endtask

  task automatic check(input logic [15:0] got, input logic [15:0] exp,
                       input string what, input int step);
    if (got !== exp) begin
      $display("ERROR @ %0t: step %0d %s is %h, expected %h", $time, step, what, got, exp);
      fail_cnt++;
      grp_fail++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic report_group(input logic [7:0] grp, input int nfail);
    if (nfail == 0) begin
      $display("Test group %0d done, all checks match", grp);
    end else begin
      $display("Test group %0d done, %0d mismatches", grp, nfail);
    end
  endtask

  initial begin : main_seq
    int         n_steps;
    logic       found;
    logic [7:0] cur_grp;
    sysclk      = 1'b0;
    arst_n      = 1'b0;
    alu_clk     = 1'b0;
    uclk        = 1'b0;
    ibint_n     = 5'h1f;
    csbits      = '0;
    cd          = '0;
    sel_testmux = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    grp_fail    = 0;
    n_steps     = 0;
    found       = 1'b0;
    cur_grp     = '0;
    $readmemh("tests/cga_33_input.txt", stim);
    // Group code ff closes the list
    for (int i = 0; i < MAX_STEPS; i++) begin
      if (!found && stim_word(i, 0) == END_MARK) begin
        found   = 1'b1;
        n_steps = i;
      end
    end
    if (!found) begin
      $display("Data file tests/cga_33_input.txt is missing or has no end marker");
      fail_cnt++;
    end else if (n_steps == 0) begin
      $display("Data file tests/cga_33_input.txt holds no test steps");
      fail_cnt++;
    end else begin
      wait_cycles(3);
      #2 arst_n = 1'b1;
      load_step(0);
      cur_grp = step_grp[7:0];
      for (int s = 0; s < n_steps; s++) begin
        load_step(s);
        if (step_grp[7:0] != cur_grp) begin
          report_group(cur_grp, grp_fail);
          grp_fail = 0;
          cur_grp  = step_grp[7:0];
        end
        @(posedge sysclk);
        #2;
        apply_inputs();
        // Strobes last one cycle
        @(posedge sysclk);
        #2;
        alu_clk = 1'b0;
        uclk    = 1'b0;
        wait_cycles(SETTLE_CYCLES);
        // Sample mid cycle
        @(negedge sysclk);
        check(fidb_out, exp_fidb[15:0], "fidb_out", s);
        check(16'(pil_3_0), exp_pil[15:0], "pil_3_0", s);
        check(16'(intrq_n), exp_irq[15:0], "intrq_n", s);
        check(16'(test_4_0), exp_test[15:0], "test_4_0", s);
      end
      report_group(cur_grp, grp_fail);
    end
    $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Global cycle limit
  initial begin : watchdog
    for (int k = 0; k < MAX_CYCLES; k++) begin
      @(posedge sysclk);
    end
    $display("Timeout, simulation ran past %0d clock cycles", MAX_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- nd120_cga.f
+incdir+include
hw/cga_pkg.sv
hw/microword_decode.sv
hw/int_latch.sv
hw/int_level.sv
hw/idb_mux.sv
hw/test_mux.sv
hw/cga_33.sv
tests/tb_cga_33.sv

//--- Makefile
TOP = tb_cga_33

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f nd120_cga.f --top-module $(TOP)

sim:
	verilator --binary --timing -f nd120_cga.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/cga_33_input.txt
// grp csbits cd ibint_n sel strobes(alu,uclk) | expected fidb pil intrq_n test
// grp ff ends the list
01 0000000000000000 0000 1f 0 0 0000 0 1 00
01 0000002000000000 1234 1f 0 1 1234 0 1 00
01 000000400005beef 0000 1f 5 1 beef 0 1 05
01 000000e00000abcd 0000 1f 4 1 0000 0 1 00
02 0000000000000000 0000 0e 0 2 0000 0 1 11
02 0000000000000000 0000 00 0 0 0000 0 1 11
02 0000000000000000 0000 00 0 2 0000 0 1 1f
02 0000000000000000 0000 1f 0 2 0000 0 1 00
03 0000004a0000bc00 0000 1f 6 1 bc00 0 1 1f
03 0000004b0000000c 0000 1f 2 1 000c 0 1 0c
03 0000006000000000 0000 1f 3 1 bc00 0 1 00
03 0000008000000000 0000 1f 4 1 0c00 0 1 04
04 0000008000000000 0000 0d 1 2 dc01 d 0 0d
04 0000004a00009c00 0000 0d 1 1 9c00 a 1 1a
04 0000004b0000000a 0000 0d 1 1 000a a 1 1a
04 0000004b00000009 0000 0d 1 1 0009 a 0 0a
04 0000008000000000 0000 0d 2 1 a901 a 0 09
04 0000008000000000 0000 0c 0 2 f901 f 0 19
04 0000006000000000 0000 0c 6 1 9c00 f 0 17
05 aa80003500070000 5a5a 0c 0 1 5a5a f 0 19
05 aa80003500070000 5a5a 0c 1 0 5a5a f 0 0f
05 aa80003500070000 5a5a 0c 2 0 5a5a f 0 09
05 aa80003500070000 5a5a 0c 3 0 5a5a f 0 15
05 aa80003500070000 5a5a 0c 4 0 5a5a f 0 01
05 aa80003500070000 5a5a 0c 5 0 5a5a f 0 07
05 aa80003500070000 5a5a 0c 6 0 5a5a f 0 17
05 aa80003500070000 5a5a 0c 7 0 5a5a f 0 00
ff 0000000000000000 0000 00 0 0 0000 0 0 00
